//--- hw/common.sv
`default_nettype none

package common;

    // ------------------------------------------------------------------
    // widths with a meaning
    // ------------------------------------------------------------------

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regaddr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011
    } opcode_t;

    // branch conditions.
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // shifts, where funct7 bit 5 is meaningful for immediates too.
    localparam funct3_t F3_SLL     = 3'b001;
    localparam funct3_t F3_SRL_SRA = 3'b101;

    // system group.
    localparam funct3_t F3_PRIV   = 3'b000;
    localparam funct3_t F3_CSRRW  = 3'b001;
    localparam funct3_t F3_CSRRS  = 3'b010;
    localparam funct3_t F3_CSRRC  = 3'b011;
    localparam funct3_t F3_CSRRWI = 3'b101;
    localparam funct3_t F3_CSRRSI = 3'b110;
    localparam funct3_t F3_CSRRCI = 3'b111;

    // ------------------------------------------------------------------
    // control word
    // ------------------------------------------------------------------

    // alu modes are {funct7[5], funct3}; copy and don't-care take unused codes.
    typedef enum logic [3:0] {
        ALU_ADD   = 4'b0000,
        ALU_SLL   = 4'b0001,
        ALU_SLT   = 4'b0010,
        ALU_SLTU  = 4'b0011,
        ALU_XOR   = 4'b0100,
        ALU_SRL   = 4'b0101,
        ALU_OR    = 4'b0110,
        ALU_AND   = 4'b0111,
        ALU_SUB   = 4'b1000,
        ALU_COPY1 = 4'b1001,
        ALU_SRA   = 4'b1101,
        ALU_X     = 4'b1111
    } alu_mode_t;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_t;
    typedef enum logic [1:0] {ALU_OP1_RS1, ALU_OP1_IMMU, ALU_OP1_X} alu_op1_t;
    typedef enum logic [2:0] {
        ALU_OP2_RS2, ALU_OP2_IMMI, ALU_OP2_IMMS, ALU_OP2_PC, ALU_OP2_X
    } alu_op2_t;
    typedef enum logic [1:0] {MA_X, MA_LOAD, MA_STORE} ma_mode_t;

    // access sizes match funct3 of loads and stores.
    typedef enum logic [2:0] {
        MA_SIZE_B  = 3'b000,
        MA_SIZE_H  = 3'b001,
        MA_SIZE_W  = 3'b010,
        MA_SIZE_BU = 3'b100,
        MA_SIZE_HU = 3'b101,
        MA_SIZE_X  = 3'b111
    } ma_size_t;

    typedef enum logic [1:0] {WB_SRC_ALU, WB_SRC_PC4, WB_SRC_MEM, WB_SRC_X} wb_src_t;

    typedef struct packed {
        logic      halt;
        pc_mode_t  pc_mode;
        alu_op1_t  alu_op1;
        alu_op2_t  alu_op2;
        alu_mode_t alu_mode;
        ma_mode_t  ma_mode;
        ma_size_t  ma_size;
        wb_src_t   wb_src;
        logic      wb_valid;
        logic      ra_used;
        logic      rb_used;
        logic      csr_used;
        logic      priv;
    } control_word_t;

    typedef struct packed {
        word_t imm_i;
        word_t imm_s;
        word_t imm_b;
        word_t imm_u;
        word_t imm_j;
    } imm_set_t;

endpackage

`default_nettype wire

//--- hw/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
    input  wire common::word_t    instr,
    output common::control_word_t cw
);

    common::opcode_t   opcode;
    common::regaddr_t  rd;
    common::funct3_t   f3;
    common::regaddr_t  rs1;
    common::regaddr_t  rs2;
    common::funct7_t   f7;
    common::alu_mode_t r_mode;
    common::alu_mode_t i_mode;
    logic              is_shift;

    assign opcode = common::opcode_t'(instr[6:0]);
    assign rd     = instr[11:7];
    assign f3     = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign f7     = instr[31:25];

    // register-immediate ops have no SUB, so bit 30 only selects SRAI.
    assign is_shift = (f3 == common::F3_SLL) || (f3 == common::F3_SRL_SRA);
    assign r_mode   = common::alu_mode_t'({f7[5], f3});
    assign i_mode   = common::alu_mode_t'({f7[5] & is_shift, f3});

    always_comb begin
        cw = '{
            pc_mode:  common::PC_NEXT,
            alu_op1:  common::ALU_OP1_X,
            alu_op2:  common::ALU_OP2_X,
            alu_mode: common::ALU_X,
            ma_mode:  common::MA_X,
            ma_size:  common::MA_SIZE_X,
            wb_src:   common::WB_SRC_X,
            default:  1'b0
        };
        unique casez ({f3, opcode})
            {3'b???, common::OP_IMM}: begin
                cw.alu_op1  = common::ALU_OP1_RS1;
                cw.alu_op2  = common::ALU_OP2_IMMI;
                cw.alu_mode = i_mode;
                cw.wb_src   = common::WB_SRC_ALU;
                cw.ra_used  = 1'b1;
            end
            {3'b???, common::OP_LUI}: begin
                cw.alu_op1  = common::ALU_OP1_IMMU;
                cw.alu_op2  = common::ALU_OP2_RS2;
                cw.alu_mode = common::ALU_COPY1;
                cw.wb_src   = common::WB_SRC_ALU;
            end
            {3'b???, common::OP_AUIPC}: begin
                cw.alu_op1  = common::ALU_OP1_IMMU;
                cw.alu_op2  = common::ALU_OP2_PC;
                cw.alu_mode = common::ALU_ADD;
                cw.wb_src   = common::WB_SRC_ALU;
            end
            {3'b???, common::OP}: begin
                cw.alu_op1  = common::ALU_OP1_RS1;
                cw.alu_op2  = common::ALU_OP2_RS2;
                cw.alu_mode = r_mode;
                cw.wb_src   = common::WB_SRC_ALU;
                cw.ra_used  = 1'b1;
                cw.rb_used  = 1'b1;
            end
            {3'b???, common::OP_JAL}: begin
                cw.pc_mode = common::PC_JUMP_REL;
                cw.wb_src  = common::WB_SRC_PC4;
            end
            {3'b???, common::OP_JALR}: begin
                cw.pc_mode = common::PC_JUMP_ABS;
                cw.wb_src  = common::WB_SRC_PC4;
                cw.ra_used = 1'b1;
            end
            {common::F3_BEQ, common::OP_BRANCH}, {common::F3_BNE, common::OP_BRANCH},
            {common::F3_BLT, common::OP_BRANCH}, {common::F3_BGE, common::OP_BRANCH},
            {common::F3_BLTU, common::OP_BRANCH}, {common::F3_BGEU, common::OP_BRANCH}: begin
                cw.pc_mode = common::PC_BRANCH;
                cw.ra_used = 1'b1;
                cw.rb_used = 1'b1;
            end
            {3'b???, common::OP_LOAD}, {3'b???, common::OP_STORE}: begin
                // both compute rs1 + offset; stores take the S-format offset.
                cw.alu_op1  = common::ALU_OP1_RS1;
                cw.alu_mode = common::ALU_ADD;
                cw.ma_size  = common::ma_size_t'(f3);
                cw.ra_used  = 1'b1;
                if (opcode == common::OP_LOAD) begin
                    cw.alu_op2 = common::ALU_OP2_IMMI;
                    cw.ma_mode = common::MA_LOAD;
                    cw.wb_src  = common::WB_SRC_MEM;
                end else begin
                    cw.alu_op2 = common::ALU_OP2_IMMS;
                    cw.ma_mode = common::MA_STORE;
                    cw.rb_used = 1'b1;
                end
            end
            {3'b???, common::OP_MISC_MEM}: begin
                // fence has nothing to order in this core.
            end
            {common::F3_PRIV, common::OP_SYSTEM}: cw.priv = 1'b1;
            {common::F3_CSRRW, common::OP_SYSTEM}, {common::F3_CSRRS, common::OP_SYSTEM},
            {common::F3_CSRRC, common::OP_SYSTEM}: begin
                cw.csr_used = 1'b1;
                cw.ra_used  = 1'b1;
            end
            {common::F3_CSRRWI, common::OP_SYSTEM}, {common::F3_CSRRSI, common::OP_SYSTEM},
            {common::F3_CSRRCI, common::OP_SYSTEM}: cw.csr_used = 1'b1;
            default: cw.halt = 1'b1;
        endcase

        cw.ra_used  = cw.ra_used && (rs1 != '0);
        cw.rb_used  = cw.rb_used && (rs2 != '0);
        cw.wb_valid = (cw.wb_src != common::WB_SRC_X) && (rd != '0);
    end

    // an illegal word must never reach the register file.
    always_comb begin
        assert (!(cw.halt && cw.wb_valid))
            else $error("decoder: halt with writeback for %h", instr);
    end

endmodule

`default_nettype wire

//--- hw/imm_gen.sv
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  wire common::word_t instr,
    output common::imm_set_t   imm
);

    logic sign;

    assign sign = instr[31];

    // every format keeps its sign in bit 31 of the instruction.
    always_comb begin
        imm.imm_i = {{20{sign}}, instr[31:20]};
        imm.imm_s = {{20{sign}}, instr[31:25], instr[11:7]};
        imm.imm_b = {{20{sign}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm.imm_u = {instr[31:12], 12'b0};
        imm.imm_j = {{12{sign}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    end

endmodule

`default_nettype wire

//--- hw/regfile.sv
`timescale 1ns/1ps
`default_nettype none

module regfile #(
    parameter int REG_COUNT = 32
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire common::regaddr_t   rs1,
    input  wire common::regaddr_t   rs2,
    output common::word_t           rs1_data,
    output common::word_t           rs2_data,
    input  wire                     we,
    input  wire common::regaddr_t   rd,
    input  wire common::word_t      rd_data
);

    localparam int IDX_W = $clog2(REG_COUNT);

    common::word_t regs [REG_COUNT];

    // x0 and any index past the file read as zero.
    assign rs1_data = (rs1 == '0 || int'(rs1) >= REG_COUNT) ? '0 : regs[rs1[IDX_W-1:0]];
    assign rs2_data = (rs2 == '0 || int'(rs2) >= REG_COUNT) ? '0 : regs[rs2[IDX_W-1:0]];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd[IDX_W-1:0]] <= rd_data;
        end
    end

    // an RV32E-sized file must not see writes to x16 and up.
    a_rd_in_range: assert property (@(posedge clk) disable iff (rst)
        we |-> int'(rd) < REG_COUNT);

endmodule

`default_nettype wire

//--- hw/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  wire common::control_word_t cw,
    input  wire common::word_t         pc,
    input  wire common::word_t         rs1_data,
    input  wire common::word_t         rs2_data,
    input  wire common::imm_set_t      imm,
    output common::word_t              result
);

    common::word_t op1;
    common::word_t op2;
    logic [4:0]    shamt;

    always_comb begin
        case (cw.alu_op1)
            common::ALU_OP1_RS1:  op1 = rs1_data;
            common::ALU_OP1_IMMU: op1 = imm.imm_u;
            default:              op1 = '0;
        endcase
        case (cw.alu_op2)
            common::ALU_OP2_RS2:  op2 = rs2_data;
            common::ALU_OP2_IMMI: op2 = imm.imm_i;
            common::ALU_OP2_IMMS: op2 = imm.imm_s;
            common::ALU_OP2_PC:   op2 = pc;
            default:              op2 = '0;
        endcase
    end

    assign shamt = op2[4:0];

    always_comb begin
        case (cw.alu_mode)
            common::ALU_ADD:   result = op1 + op2;
            common::ALU_SUB:   result = op1 - op2;
            common::ALU_SLL:   result = op1 << shamt;
            common::ALU_SLT:   result = {31'b0, $signed(op1) < $signed(op2)};
            common::ALU_SLTU:  result = {31'b0, op1 < op2};
            common::ALU_XOR:   result = op1 ^ op2;
            common::ALU_SRL:   result = op1 >> shamt;
            common::ALU_SRA:   result = common::word_t'($signed(op1) >>> shamt);
            common::ALU_OR:    result = op1 | op2;
            common::ALU_AND:   result = op1 & op2;
            common::ALU_COPY1: result = op1;
            default:           result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/next_pc.sv
`timescale 1ns/1ps
`default_nettype none

module next_pc (
    input  wire common::control_word_t cw,
    input  wire common::funct3_t       funct3,
    input  wire common::word_t         pc,
    input  wire common::word_t         rs1_data,
    input  wire common::word_t         rs2_data,
    input  wire common::imm_set_t      imm,
    output common::word_t              npc
);

    logic          taken;
    common::word_t jalr_target;

    always_comb begin
        case (funct3)
            common::F3_BEQ:  taken = rs1_data == rs2_data;
            common::F3_BNE:  taken = rs1_data != rs2_data;
            common::F3_BLT:  taken = $signed(rs1_data) < $signed(rs2_data);
            common::F3_BGE:  taken = $signed(rs1_data) >= $signed(rs2_data);
            common::F3_BLTU: taken = rs1_data < rs2_data;
            common::F3_BGEU: taken = rs1_data >= rs2_data;
            default:         taken = 1'b0;
        endcase
    end

    // jalr drops bit 0 of the sum.
    assign jalr_target = (rs1_data + imm.imm_i) & ~32'd1;

    always_comb begin
        case (cw.pc_mode)
            common::PC_JUMP_REL: npc = pc + imm.imm_j;
            common::PC_JUMP_ABS: npc = jalr_target;
            common::PC_BRANCH:   npc = taken ? pc + imm.imm_b : pc + 32'd4;
            default:             npc = pc + 32'd4;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
    parameter common::word_t RESET_PC  = '0,
    parameter int            REG_COUNT = 32
) (
    input  wire                   clk,
    input  wire                   rst,
    output common::word_t         pc,
    input  wire common::word_t    instr,
    output common::word_t         dmem_addr,
    output common::word_t         dmem_wdata,
    output common::ma_size_t      dmem_size,
    output logic                  dmem_we,
    input  wire common::word_t    dmem_rdata,
    output logic                  retire_valid,
    output common::word_t         retire_pc,
    output common::regaddr_t      retire_rd,
    output common::word_t         retire_data,
    output logic                  halted
);

    common::control_word_t cw;
    common::imm_set_t      imm;
    common::regaddr_t      rd;
    common::word_t         rs1_data;
    common::word_t         rs2_data;
    common::word_t         alu_result;
    common::word_t         npc;
    common::word_t         load_data;
    common::word_t         wb_data;
    logic                  stop;
    logic                  exec;
    logic                  wb_en;

    assign rd = instr[11:7];

    decoder decoder_i (.instr(instr), .cw(cw));
    imm_gen imm_gen_i (.instr(instr), .imm(imm));

    regfile #(.REG_COUNT(REG_COUNT)) regfile_i (
        .clk(clk), .rst(rst),
        .rs1(instr[19:15]), .rs2(instr[24:20]),
        .rs1_data(rs1_data), .rs2_data(rs2_data),
        .we(wb_en), .rd(rd), .rd_data(wb_data)
    );

    alu alu_i (
        .cw(cw), .pc(pc), .rs1_data(rs1_data), .rs2_data(rs2_data),
        .imm(imm), .result(alu_result)
    );

    next_pc next_pc_i (
        .cw(cw), .funct3(instr[14:12]), .pc(pc), .rs1_data(rs1_data),
        .rs2_data(rs2_data), .imm(imm), .npc(npc)
    );

    // ------------------------------------------------------------------
    // execute and writeback
    // ------------------------------------------------------------------

    // ecall and ebreak stop the core just like an illegal word.
    assign stop  = cw.halt || cw.priv;
    assign exec  = !halted && !stop;
    assign wb_en = exec && cw.wb_valid;

    assign dmem_addr  = alu_result;
    assign dmem_wdata = rs2_data;
    assign dmem_size  = cw.ma_size;
    assign dmem_we    = !rst && exec && (cw.ma_mode == common::MA_STORE);

    always_comb begin
        case (cw.ma_size)
            common::MA_SIZE_B:  load_data = {{24{dmem_rdata[7]}}, dmem_rdata[7:0]};
            common::MA_SIZE_H:  load_data = {{16{dmem_rdata[15]}}, dmem_rdata[15:0]};
            common::MA_SIZE_BU: load_data = {24'b0, dmem_rdata[7:0]};
            common::MA_SIZE_HU: load_data = {16'b0, dmem_rdata[15:0]};
            default:            load_data = dmem_rdata;
        endcase
        case (cw.wb_src)
            common::WB_SRC_PC4: wb_data = pc + 32'd4;
            common::WB_SRC_MEM: wb_data = load_data;
            default:            wb_data = alu_result;
        endcase
    end

    // ------------------------------------------------------------------
    // state and retire record
    // ------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            pc           <= RESET_PC;
            halted       <= 1'b0;
            retire_valid <= 1'b0;
            retire_rd    <= '0;
        end else begin
            if (exec) begin
                pc <= npc;
            end
            if (stop) begin
                halted <= 1'b1;
            end
            retire_valid <= exec;
            retire_rd    <= wb_en ? rd : '0;
        end
    end

    always_ff @(posedge clk) begin
        retire_pc   <= pc;
        retire_data <= wb_data;
    end

endmodule

`default_nettype wire

//--- test/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// ----------------------------------------------------------------------
// random numbers and instruction encoders
// ----------------------------------------------------------------------

logic [31:0] lcg_state = 32'h0e3f_7d1a;

function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

function automatic logic [31:0] enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3, logic [4:0] rd, logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                      logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                      logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] op);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] enc_j(logic [20:0] imm, logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

// ----------------------------------------------------------------------
// reference rules of the shadow model
// ----------------------------------------------------------------------

// alt is instruction bit 30, which picks SUB and SRA.
function automatic logic [31:0] alu_ref(logic [2:0] f3, logic alt, logic [31:0] a,
                                        logic [31:0] b);
    case (f3)
        3'd0:    return alt ? a - b : a + b;
        3'd1:    return a << b[4:0];
        3'd2:    return {31'b0, $signed(a) < $signed(b)};
        3'd3:    return {31'b0, a < b};
        3'd4:    return a ^ b;
        3'd5:    return alt ? $signed(a) >>> b[4:0] : a >> b[4:0];
        3'd6:    return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branch_taken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
        3'd0:    return a == b;
        3'd1:    return a != b;
        3'd4:    return $signed(a) < $signed(b);
        3'd5:    return $signed(a) >= $signed(b);
        3'd6:    return a < b;
        default: return a >= b;
    endcase
endfunction

// ebreak, ecall and the all-zero word all stop the core.
function automatic logic is_halt_word(logic [31:0] w);
    return (w == 32'h0) || (w[6:0] == 7'h73 && w[14:12] == 3'd0);
endfunction

`endif

//--- test/tb_core_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core_top;

    localparam common::word_t RESET_PC = 32'h0;
    localparam int PROG_WORDS = 256;
    localparam int LIMIT = 2 * (8 + 2 * PROG_WORDS + 20);

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    common::word_t     pc;
    common::word_t     instr = '0;
    common::word_t     dmem_addr;
    common::word_t     dmem_wdata;
    common::ma_size_t  dmem_size;
    logic              dmem_we;
    common::word_t     dmem_rdata;
    logic              retire_valid;
    common::word_t     retire_pc;
    common::regaddr_t  retire_rd;
    common::word_t     retire_data;
    logic              halted;

    logic [31:0] prog [PROG_WORDS];
    logic [7:0]  dmem [256];
    logic [7:0]  mmem [256];
    logic [31:0] mregs [32];
    logic [31:0] mpc;
    logic        model_halt;
    logic [31:0] exp_pc;
    logic [4:0]  exp_rd;
    logic [31:0] exp_data;
    logic        exp_chk;
    logic [7:0]  da;
    int          wp;
    int          cycles = 0;

    `include "tb_model.svh"

    core_top #(.RESET_PC(RESET_PC), .REG_COUNT(32)) dut_i (
        .clk(clk), .rst(rst), .pc(pc), .instr(instr),
        .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata), .dmem_size(dmem_size),
        .dmem_we(dmem_we), .dmem_rdata(dmem_rdata),
        .retire_valid(retire_valid), .retire_pc(retire_pc), .retire_rd(retire_rd),
        .retire_data(retire_data), .halted(halted)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------------
    // memories
    // ------------------------------------------------------------------

    assign da = dmem_addr[7:0];
    assign dmem_rdata = {dmem[da + 8'd3], dmem[da + 8'd2], dmem[da + 8'd1], dmem[da]};

    always @(negedge clk) begin
        instr <= prog[pc[9:2]];
    end

    always @(posedge clk) begin
        if (dmem_we) begin
            dmem[da] <= dmem_wdata[7:0];
            if (dmem_size[1:0] != 2'd0) begin
                dmem[da + 8'd1] <= dmem_wdata[15:8];
            end
            if (dmem_size[1:0] == 2'd2) begin
                dmem[da + 8'd2] <= dmem_wdata[23:16];
                dmem[da + 8'd3] <= dmem_wdata[31:24];
            end
        end
    end

    // ------------------------------------------------------------------
    // shadow model, stepped once per retired instruction
    // ------------------------------------------------------------------

    task automatic model_step();
        logic [31:0] w, a, b, ii, is, ib, iu, ij, val, npc, addr;
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [7:0]  ad;
        logic        wr;
        w  = prog[mpc[9:2]];
        f3 = w[14:12];
        rd = w[11:7];
        a  = mregs[w[19:15]];
        b  = mregs[w[24:20]];
        ii = {{20{w[31]}}, w[31:20]};
        is = {{20{w[31]}}, w[31:25], w[11:7]};
        ib = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        iu = {w[31:12], 12'b0};
        ij = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        npc = mpc + 32'd4;
        wr  = 1'b1;
        val = '0;
        case (w[6:0])
            7'h33: val = alu_ref(f3, w[30], a, b);
            7'h13: val = alu_ref(f3, w[30] && f3 == 3'd5, a, ii);
            7'h37: val = iu;
            7'h17: val = mpc + iu;
            7'h6f: begin
                val = mpc + 32'd4;
                npc = mpc + ij;
            end
            7'h67: begin
                val = mpc + 32'd4;
                npc = (a + ii) & ~32'd1;
            end
            7'h63: begin
                wr = 1'b0;
                if (branch_taken(f3, a, b)) begin
                    npc = mpc + ib;
                end
            end
            7'h03: begin
                addr = a + ii;
                ad   = addr[7:0];
                case (f3)
                    3'd0:    val = {{24{mmem[ad][7]}}, mmem[ad]};
                    3'd1:    val = {{16{mmem[ad + 8'd1][7]}}, mmem[ad + 8'd1], mmem[ad]};
                    3'd4:    val = {24'b0, mmem[ad]};
                    3'd5:    val = {16'b0, mmem[ad + 8'd1], mmem[ad]};
                    default: val = {mmem[ad + 8'd3], mmem[ad + 8'd2], mmem[ad + 8'd1], mmem[ad]};
                endcase
            end
            7'h23: begin
                wr   = 1'b0;
                addr = a + is;
                ad   = addr[7:0];
                mmem[ad] = b[7:0];
                if (f3 != 3'd0) begin
                    mmem[ad + 8'd1] = b[15:8];
                end
                if (f3 == 3'd2) begin
                    mmem[ad + 8'd2] = b[23:16];
                    mmem[ad + 8'd3] = b[31:24];
                end
            end
            default: wr = 1'b0;
        endcase
        exp_pc   = mpc;
        exp_rd   = (wr && rd != 5'd0) ? rd : 5'd0;
        exp_data = val;
        exp_chk  = wr;
        if (wr && rd != 5'd0) begin
            mregs[rd] = val;
        end
        mpc = npc;
    endtask

    always @(negedge clk) begin
        if (rst) begin
            mpc        = RESET_PC;
            model_halt = 1'b0;
            exp_chk    = 1'b0;
            for (int i = 0; i < 32; i++) begin
                mregs[i] = '0;
            end
            for (int i = 0; i < 256; i++) begin
                mmem[i] = '0;
            end
        end else begin
            if (retire_valid) begin
                model_step();
            end
            if (is_halt_word(prog[mpc[9:2]])) begin
                model_halt = 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------
    // checks
    // ------------------------------------------------------------------

    task automatic finish_fail();
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic report_value(string name, logic [31:0] got, logic [31:0] want);
        $display("FAIL t=%0t %s dut=%h exp=%h", $time, name, got, want);
        finish_fail();
    endtask

    task automatic report_text(string msg);
        $display("t=%0t %s", $time, msg);
        finish_fail();
    endtask

    a_reset: assert property (@(posedge clk) rst |=> pc == RESET_PC && !retire_valid && !halted)
        else report_text("state after reset is not clean");
    a_ret_pc: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_pc == exp_pc)
        else report_value("retire_pc", $sampled(retire_pc), $sampled(exp_pc));
    a_ret_rd: assert property (@(posedge clk) disable iff (rst)
        retire_valid |-> retire_rd == exp_rd)
        else report_value("retire_rd", 32'($sampled(retire_rd)), 32'($sampled(exp_rd)));
    a_ret_data: assert property (@(posedge clk) disable iff (rst)
        retire_valid && exp_chk |-> retire_data == exp_data)
        else report_value("retire_data", $sampled(retire_data), $sampled(exp_data));
    a_retires: assert property (@(posedge clk) disable iff (rst) !model_halt |=> retire_valid)
        else report_text("an instruction did not retire");
    a_halt_rise: assert property (@(posedge clk) disable iff (rst)
        model_halt |=> halted && !retire_valid)
        else report_text("core did not halt at a halting instruction");
    a_halt_only: assert property (@(posedge clk) disable iff (rst) halted |-> model_halt)
        else report_text("core halted early");
    a_pc_hold: assert property (@(posedge clk) disable iff (rst) halted |=> $stable(pc))
        else report_text("pc moved while halted");
    a_store_we: assert property (@(posedge clk) disable iff (rst)
        dmem_we == (instr[6:0] == 7'h23 && !model_halt))
        else report_value("dmem_we", 32'($sampled(dmem_we)), 32'(!$sampled(dmem_we)));

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            report_text("timeout, the core never halted");
        end
    end

    // ------------------------------------------------------------------
    // programs
    // ------------------------------------------------------------------

    task automatic emit(logic [31:0] w);
        prog[wp] = w;
        wp++;
    endtask

    // a taken branch skips the increment of x26.
    task automatic add_branch(logic [2:0] f3, logic [4:0] rs1, logic [4:0] rs2);
        emit(enc_b(13'd8, rs2, rs1, f3));
        emit(enc_i(12'd1, 5'd26, 3'd0, 5'd26, 7'h13));
    endtask

    task automatic build_main_program();
        logic [31:0] r;
        logic [11:0] imm;
        for (int i = 0; i < 120; i++) begin
            r   = lcg_next();
            imm = r[31:20];
            if (r[12]) begin
                if (r[2:0] == 3'd1) begin
                    imm = {7'b0, r[24:20]};
                end else if (r[2:0] == 3'd5) begin
                    imm = {1'b0, r[13], 5'b0, r[24:20]};
                end
                emit(enc_i(imm, {2'b0, r[8:6]}, r[2:0], {2'b0, r[5:3]}, 7'h13));
            end else begin
                emit(enc_r((r[13] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'h20 : 7'h00,
                           {2'b0, r[11:9]}, {2'b0, r[8:6]}, r[2:0], {2'b0, r[5:3]}, 7'h33));
            end
        end
        emit(enc_u(20'h12345, 5'd10, 7'h37));
        emit(enc_u(20'h00010, 5'd11, 7'h17));
        emit(enc_i(12'h040, 5'd0, 3'd0, 5'd12, 7'h13));
        emit(enc_u(20'h89abd, 5'd13, 7'h37));
        emit(enc_i(12'hdef, 5'd13, 3'd0, 5'd13, 7'h13));
        emit(enc_s(12'd0, 5'd13, 5'd12, 3'd2));
        emit(enc_i(12'd0, 5'd12, 3'd2, 5'd14, 7'h03));
        emit(enc_i(12'd2, 5'd12, 3'd1, 5'd15, 7'h03));
        emit(enc_i(12'd2, 5'd12, 3'd5, 5'd16, 7'h03));
        emit(enc_i(12'd3, 5'd12, 3'd0, 5'd17, 7'h03));
        emit(enc_i(12'd1, 5'd12, 3'd4, 5'd18, 7'h03));
        emit(enc_s(12'd8, 5'd13, 5'd12, 3'd0));
        emit(enc_i(12'd8, 5'd12, 3'd0, 5'd19, 7'h03));
        emit(enc_i(12'd8, 5'd12, 3'd4, 5'd20, 7'h03));
        // the byte above a byte store must still read as zero.
        emit(enc_i(12'd9, 5'd12, 3'd4, 5'd31, 7'h03));
        emit(enc_s(12'd12, 5'd13, 5'd12, 3'd1));
        emit(enc_i(12'd12, 5'd12, 3'd1, 5'd21, 7'h03));
        emit(enc_i(12'd12, 5'd12, 3'd5, 5'd22, 7'h03));
        emit(enc_i(12'd12, 5'd12, 3'd2, 5'd23, 7'h03));
        emit(enc_i(12'hfff, 5'd0, 3'd0, 5'd24, 7'h13));
        emit(enc_i(12'd1, 5'd0, 3'd0, 5'd25, 7'h13));
        add_branch(3'd0, 5'd25, 5'd25);
        add_branch(3'd0, 5'd25, 5'd24);
        add_branch(3'd1, 5'd25, 5'd24);
        add_branch(3'd1, 5'd25, 5'd25);
        add_branch(3'd4, 5'd24, 5'd25);
        add_branch(3'd4, 5'd25, 5'd24);
        add_branch(3'd5, 5'd25, 5'd24);
        add_branch(3'd5, 5'd24, 5'd25);
        add_branch(3'd6, 5'd25, 5'd24);
        add_branch(3'd6, 5'd24, 5'd25);
        add_branch(3'd7, 5'd24, 5'd25);
        add_branch(3'd7, 5'd25, 5'd24);
        emit(enc_j(21'd8, 5'd27));
        emit(enc_i(12'd1, 5'd26, 3'd0, 5'd26, 7'h13));
        // the odd offset checks that jalr clears bit 0 of its target.
        emit(enc_u(20'h0, 5'd28, 7'h17));
        emit(enc_i(12'd13, 5'd28, 3'd0, 5'd29, 7'h67));
        emit(enc_i(12'd1, 5'd26, 3'd0, 5'd26, 7'h13));
        emit(enc_r(7'h00, 5'd27, 5'd26, 3'd0, 5'd30, 7'h33));
        emit(32'h0010_0073);
    endtask

    task automatic run_to_halt();
        repeat (8) @(negedge clk);
        rst <= 1'b0;
        while (!halted) begin
            @(posedge clk);
        end
        repeat (6) @(posedge clk);
    endtask

    initial begin
        for (int i = 0; i < 256; i++) begin
            prog[i] = '0;
            dmem[i] = '0;
        end
        wp = 0;
        build_main_program();
        run_to_halt();

        // second section ends at an all-zero illegal word.
        @(negedge clk);
        rst <= 1'b1;
        for (int i = 0; i < PROG_WORDS; i++) begin
            prog[i] = '0;
        end
        wp = 0;
        emit(enc_i(12'd5, 5'd0, 3'd0, 5'd1, 7'h13));
        emit(enc_r(7'h00, 5'd1, 5'd1, 3'd0, 5'd2, 7'h33));
        run_to_halt();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+test
hw/common.sv
hw/decoder.sv
hw/imm_gen.sv
hw/regfile.sv
hw/alu.sv
hw/next_pc.sv
hw/core_top.sv
test/tb_core_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the core testbench with Verilator.
set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core_top -Mdir obj_dir -f filelist.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_core_top > sim.log 2>&1
run_status=$?
cat sim.log

if grep -q "Simulation finished: PASS" sim.log; then
    exit 0
fi
echo "simulation did not pass (exit status ${run_status})"
exit 1
